// ==== src/simd_params.svh ====
`ifndef SIMD_PARAMS_SVH
`define SIMD_PARAMS_SVH

// Vector geometry
`define SIMD_VLEN 128
`define SIMD_ELEN 64
`define SIMD_LANES 2

// One mask bit per element at SEW 8
`define SIMD_VM_W 16

// Latency classes in cycles
`define SIMD_LAT_ALU 1
`define SIMD_LAT_MUL 2
`define SIMD_MAX_LAT 3  // VMUL at SEW 64

`endif

// ==== src/simd_pkg.sv ====
`default_nettype none
`include "simd_params.svh"

package simd_pkg;

typedef logic [`SIMD_VLEN-1:0] vreg_t;
typedef logic [`SIMD_ELEN-1:0] lane_t;
typedef logic [`SIMD_VM_W-1:0] vmask_t;
typedef logic [63:0]           xreg_t;
typedef logic [4:0]            reg_idx_t;
typedef logic [1:0]            lat_t;

typedef enum logic [1:0] {
    SEW_8,
    SEW_16,
    SEW_32,
    SEW_64
} sew_e;

typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMUL,
    VMERGE,
    VMV_X_S
} vop_e;

typedef struct packed {
    logic              valid;
    vop_e              op;
    sew_e              sew;
    logic              is_opvx;     // Vector-scalar form
    logic              is_opvi;     // Vector-immediate form
    logic              use_mask;
    reg_idx_t          vd;
    reg_idx_t          rd;
    vreg_t             data_vs1;
    vreg_t             data_vs2;
    vreg_t             data_old_vd;
    vmask_t            data_vm;
    xreg_t             data_rs1;
    logic signed [4:0] imm;
} simd_issue_t;

// Operands of one 64-bit lane, m holds one bit per element of the lane
typedef struct packed {
    lane_t                   a;
    lane_t                   b;
    logic [`SIMD_ELEN/8-1:0] m;
} lane_ops_t;

typedef struct packed {
    logic     valid;
    reg_idx_t vd;
    vreg_t    vresult;
} wb_vec_t;

typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xreg_t    result;
} wb_scalar_t;

endpackage

`default_nettype wire

// ==== src/simd_operand_prep.sv ====
`default_nettype none
`include "simd_params.svh"

module simd_operand_prep
    import simd_pkg::*;
(
    input  wire simd_issue_t             instruction_i,
    output lane_ops_t [`SIMD_LANES-1:0] lane_ops_o
);

xreg_t scalar_src;
vreg_t scalar_rep;
vreg_t vs1_sel;

always_comb begin
    if (instruction_i.is_opvx) begin
        scalar_src = instruction_i.data_rs1;
    end else begin
        scalar_src = {{($bits(xreg_t)-5){instruction_i.imm[4]}}, instruction_i.imm};
    end

    // Fill the whole vector with the scalar at the element width
    case (instruction_i.sew)
        SEW_8:   scalar_rep = {(`SIMD_VLEN/8){scalar_src[7:0]}};
        SEW_16:  scalar_rep = {(`SIMD_VLEN/16){scalar_src[15:0]}};
        SEW_32:  scalar_rep = {(`SIMD_VLEN/32){scalar_src[31:0]}};
        default: scalar_rep = {(`SIMD_VLEN/64){scalar_src}};
    endcase

    if (instruction_i.is_opvx || instruction_i.is_opvi) begin
        vs1_sel = scalar_rep;
    end else begin
        vs1_sel = instruction_i.data_vs1;
    end
end

always_comb begin
    for (int l = 0; l < `SIMD_LANES; l++) begin
        lane_ops_o[l].a = vs1_sel[l*`SIMD_ELEN +: `SIMD_ELEN];
        lane_ops_o[l].b = instruction_i.data_vs2[l*`SIMD_ELEN +: `SIMD_ELEN];
        lane_ops_o[l].m = '1;  // Every element active when unmasked
        if (instruction_i.use_mask) begin
            case (instruction_i.sew)
                SEW_8:   lane_ops_o[l].m = instruction_i.data_vm[l*8 +: 8];
                SEW_16:  lane_ops_o[l].m = {4'b0, instruction_i.data_vm[l*4 +: 4]};
                SEW_32:  lane_ops_o[l].m = {6'b0, instruction_i.data_vm[l*2 +: 2]};
                default: lane_ops_o[l].m = {7'b0, instruction_i.data_vm[l]};
            endcase
        end
    end
end

endmodule

`default_nettype wire

// ==== src/simd_lane_fu.sv ====
`default_nettype none
`include "simd_params.svh"

module simd_lane_fu
    import simd_pkg::*;
#(
    parameter int LANE_IDX = 0
) (
    input  wire lane_ops_t ops_i,
    input  wire vop_e      op_i,
    input  wire sew_e      sew_i,
    output lane_t          result_o
);

lane_t res;

// Operands arrive zero-extended, the caller keeps only the element width
function automatic lane_t elem_op(input vop_e op, input lane_t a, input lane_t b,
                                  input logic m);
    lane_t r;
    case (op)
        VADD:    r = a + b;
        VSUB:    r = a - b;
        VAND:    r = a & b;
        VOR:     r = a | b;
        VXOR:    r = a ^ b;
        VMUL:    r = a * b;           // Low half of the product
        VMERGE:  r = m ? a : b;
        default: r = b;               // VMV_X_S carries vs2
    endcase
    return r;
endfunction

always_comb begin
    lane_t e;
    res = '0;
    case (sew_i)
        SEW_8: begin
            for (int i = 0; i < `SIMD_ELEN/8; i++) begin
                e = elem_op(op_i, lane_t'(ops_i.a[i*8 +: 8]),
                            lane_t'(ops_i.b[i*8 +: 8]), ops_i.m[i]);
                res[i*8 +: 8] = e[7:0];
            end
        end
        SEW_16: begin
            for (int i = 0; i < `SIMD_ELEN/16; i++) begin
                e = elem_op(op_i, lane_t'(ops_i.a[i*16 +: 16]),
                            lane_t'(ops_i.b[i*16 +: 16]), ops_i.m[i]);
                res[i*16 +: 16] = e[15:0];
            end
        end
        SEW_32: begin
            for (int i = 0; i < `SIMD_ELEN/32; i++) begin
                e = elem_op(op_i, lane_t'(ops_i.a[i*32 +: 32]),
                            lane_t'(ops_i.b[i*32 +: 32]), ops_i.m[i]);
                res[i*32 +: 32] = e[31:0];
            end
        end
        default: begin
            e = elem_op(op_i, ops_i.a, ops_i.b, ops_i.m[0]);
            res = e;
        end
    endcase
end

// Scalar moves only need element 0, which sits in lane 0
always_comb begin
    if ((op_i == VMV_X_S) && (LANE_IDX != 0)) begin
        result_o = '0;
    end else begin
        result_o = res;
    end
end

endmodule

`default_nettype wire

// ==== src/simd_latency_pipe.sv ====
`default_nettype none
`include "simd_params.svh"

module simd_latency_pipe
    import simd_pkg::*;
(
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire simd_issue_t instruction_i,
    input  wire vreg_t       lane_res_i,
    output simd_issue_t      done_o,
    output vreg_t            done_res_o
);

typedef struct packed {
    simd_issue_t instr;
    vreg_t       res;
} pipe_entry_t;

lat_t                   issue_lat;
logic [`SIMD_MAX_LAT:1] tail_vld;
pipe_entry_t            tail [1:`SIMD_MAX_LAT];

always_comb begin
    if (instruction_i.op != VMUL) begin
        issue_lat = lat_t'(`SIMD_LAT_ALU);
    end else if (instruction_i.sew == SEW_64) begin
        issue_lat = lat_t'(`SIMD_MAX_LAT);
    end else begin
        issue_lat = lat_t'(`SIMD_LAT_MUL);
    end
end

// One shift track per latency class, track d holds d slots
for (genvar d = 1; d <= `SIMD_MAX_LAT; d++) begin : g_track
    logic         push;
    logic [d-1:0] vld_q;
    pipe_entry_t  slot_q [d];

    assign push = instruction_i.valid && (issue_lat == lat_t'(d));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= push;
            for (int s = 1; s < d; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            slot_q[0] <= '{instr: instruction_i, res: lane_res_i};
        end
        for (int s = 1; s < d; s++) begin
            slot_q[s] <= slot_q[s-1];
        end
    end

    assign tail_vld[d] = vld_q[d-1];
    assign tail[d]     = slot_q[d-1];
end

// Walk from the deepest track down so the shortest one wins a collision
always_comb begin
    done_o     = '0;
    done_res_o = '0;
    for (int d = `SIMD_MAX_LAT; d >= 1; d--) begin
        if (tail_vld[d]) begin
            done_o     = tail[d].instr;
            done_res_o = tail[d].res;
        end
    end
end

endmodule

`default_nettype wire

// ==== src/simd_writeback.sv ====
`default_nettype none
`include "simd_params.svh"

module simd_writeback
    import simd_pkg::*;
(
    input  wire simd_issue_t done_i,
    input  wire vreg_t       done_res_i,
    output wb_vec_t          wb_vec_o,
    output wb_scalar_t       wb_scalar_o
);

localparam int VBYTES = `SIMD_VLEN / 8;

logic [VBYTES-1:0] byte_en;
vreg_t             keep_data;
vreg_t             merged;
xreg_t             elem0;
logic              is_mv;

// Expand the element mask into one enable per byte
always_comb begin
    byte_en = '1;
    if (done_i.use_mask) begin
        for (int i = 0; i < VBYTES; i++) begin
            case (done_i.sew)
                SEW_8:   byte_en[i] = done_i.data_vm[i];
                SEW_16:  byte_en[i] = done_i.data_vm[i/2];
                SEW_32:  byte_en[i] = done_i.data_vm[i/4];
                default: byte_en[i] = done_i.data_vm[i/8];
            endcase
        end
    end
end

always_comb begin
    if (done_i.op == VMERGE) begin
        keep_data = done_i.data_vs2;
    end else begin
        keep_data = done_i.data_old_vd;
    end
    for (int i = 0; i < VBYTES; i++) begin
        merged[i*8 +: 8] = byte_en[i] ? done_res_i[i*8 +: 8] : keep_data[i*8 +: 8];
    end
end

// Element 0 of vs2, sign-extended to XLEN
always_comb begin
    case (done_i.sew)
        SEW_8:   elem0 = {{56{done_res_i[7]}}, done_res_i[7:0]};
        SEW_16:  elem0 = {{48{done_res_i[15]}}, done_res_i[15:0]};
        SEW_32:  elem0 = {{32{done_res_i[31]}}, done_res_i[31:0]};
        default: elem0 = done_res_i[63:0];
    endcase
end

assign is_mv = (done_i.op == VMV_X_S);

assign wb_vec_o = '{
    valid:   done_i.valid && !is_mv,
    vd:      done_i.vd,
    vresult: merged
};

assign wb_scalar_o = '{
    valid:  done_i.valid && is_mv,
    rd:     done_i.rd,
    result: elem0
};

endmodule

`default_nettype wire

// ==== src/simd_unit.sv ====
`default_nettype none
`include "simd_params.svh"

module simd_unit
    import simd_pkg::*;
(
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire simd_issue_t instruction_i,
    output wb_vec_t          wb_vec_o,
    output wb_scalar_t       wb_scalar_o
);

lane_ops_t [`SIMD_LANES-1:0] lane_ops;
vreg_t                       lane_res;   // Lane results side by side
simd_issue_t                 done;
vreg_t                       done_res;

simd_operand_prep i_operand_prep (
    .instruction_i (instruction_i),
    .lane_ops_o    (lane_ops)
);

for (genvar l = 0; l < `SIMD_LANES; l++) begin : g_lane
    simd_lane_fu #(
        .LANE_IDX (l)
    ) i_lane (
        .ops_i    (lane_ops[l]),
        .op_i     (instruction_i.op),
        .sew_i    (instruction_i.sew),
        .result_o (lane_res[l*`SIMD_ELEN +: `SIMD_ELEN])
    );
end

simd_latency_pipe i_latency_pipe (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instruction_i (instruction_i),
    .lane_res_i    (lane_res),
    .done_o        (done),
    .done_res_o    (done_res)
);

simd_writeback i_writeback (
    .done_i      (done),
    .done_res_i  (done_res),
    .wb_vec_o    (wb_vec_o),
    .wb_scalar_o (wb_scalar_o)
);

endmodule

`default_nettype wire

// ==== verif/simd_tb_model.svh ====
`ifndef SIMD_TB_MODEL_SVH
`define SIMD_TB_MODEL_SVH

`include "simd_params.svh"

// Expected vector result, worked out element by element over the whole register
function automatic vreg_t model_vec(input simd_issue_t ins);
    int          ew;
    logic [63:0] wmask;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [63:0] keep;
    vmask_t      vm;
    xreg_t       s;
    vreg_t       out;
    ew    = 8 << ins.sew;
    wmask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    s     = ins.is_opvx ? ins.data_rs1 : {{59{ins.imm[4]}}, ins.imm};
    out   = '0;
    for (int e = 0; e < `SIMD_VLEN / ew; e++) begin
        a    = (ins.is_opvx || ins.is_opvi) ? s : 64'(ins.data_vs1 >> (e * ew));
        b    = 64'(ins.data_vs2 >> (e * ew));
        keep = (ins.op == VMERGE) ? b : 64'(ins.data_old_vd >> (e * ew));
        vm   = ins.data_vm >> e;
        case (ins.op)
            VADD:    r = a + b;
            VSUB:    r = a - b;
            VAND:    r = a & b;
            VOR:     r = a | b;
            VXOR:    r = a ^ b;
            VMUL:    r = a * b;  // Low bits only depend on the low operand bits
            default: r = a;      // VMERGE takes vs1 where the element is active
        endcase
        if (ins.use_mask && !vm[0]) begin
            r = keep;
        end
        out = out | (vreg_t'(r & wmask) << (e * ew));
    end
    return out;
endfunction

// Element 0 of vs2 sign-extended from the element width
function automatic xreg_t model_scalar(input simd_issue_t ins);
    int    sh;
    xreg_t v;
    sh = 64 - (8 << ins.sew);
    v  = ins.data_vs2[63:0];
    return xreg_t'($signed(v << sh) >>> sh);
endfunction

`endif

// ==== verif/tb_simd_unit.sv ====
`default_nettype none

module tb_simd_unit
    import simd_pkg::*;
();

localparam int CLK_PERIOD   = 10;
localparam int RESET_CYCLES = 5;
localparam int DRAIN_CYCLES = 4;
localparam int N_IDLE       = 20;
localparam int N_ALU        = 400;
localparam int N_MUL        = 300;
localparam int N_MASK       = 300;
localparam int N_MOVE       = 100;
localparam int RUN_CYCLES   = RESET_CYCLES + N_IDLE + N_ALU + N_MUL + N_MASK + N_MOVE
                              + 5 * DRAIN_CYCLES;
localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

localparam int K_IDLE = 0;
localparam int K_ALU  = 1;
localparam int K_MUL  = 2;
localparam int K_MASK = 3;
localparam int K_MOVE = 4;

logic        clk_i;
logic        rstn_i;
simd_issue_t instruction_i;
wb_vec_t     wb_vec_o;
wb_scalar_t  wb_scalar_o;

integer seed;
int     cyc;
int     errors;
int     checks;
int     bubbles;

// Expected write-backs, slot is the completion cycle modulo 8
logic [7:0] exp_busy;
logic [7:0] exp_scalar;
wb_vec_t    exp_vec [8];
wb_scalar_t exp_sc  [8];

`include "simd_tb_model.svh"

simd_unit i_dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instruction_i (instruction_i),
    .wb_vec_o      (wb_vec_o),
    .wb_scalar_o   (wb_scalar_o)
);

always #(CLK_PERIOD / 2) clk_i = ~clk_i;

function automatic logic [31:0] rand32();
    rand32 = $random(seed);
endfunction

function automatic int completion_delay(input simd_issue_t ins);
    if (ins.op != VMUL) begin
        return 1;
    end
    return (ins.sew == SEW_64) ? 3 : 2;
endfunction

function automatic simd_issue_t random_instr(input int kind);
    simd_issue_t ins;
    logic [31:0] r;
    ins.data_vs1    = {rand32(), rand32(), rand32(), rand32()};
    ins.data_vs2    = {rand32(), rand32(), rand32(), rand32()};
    ins.data_old_vd = {rand32(), rand32(), rand32(), rand32()};
    ins.data_rs1    = {rand32(), rand32()};
    r = rand32();
    ins.data_vm = r[15:0];
    ins.vd      = r[20:16];
    ins.rd      = r[25:21];
    ins.imm     = r[30:26];
    r = rand32();
    ins.sew      = sew_e'(r[1:0]);
    ins.is_opvx  = (r[3:2] == 2'd1);
    ins.is_opvi  = (r[3:2] == 2'd2);  // Both low means vector-vector
    ins.use_mask = 1'b0;
    ins.valid    = (kind != K_IDLE);
    case (kind)
        K_ALU:  ins.op = vop_e'(3'(r[15:8] % 8'd5));
        K_MUL:  ins.op = (r[6:4] != 3'd0) ? VMUL : vop_e'(3'(r[15:8] % 8'd5));
        K_MASK: begin
            ins.use_mask = 1'b1;
            case (r[5:4])
                2'd0:    ins.op = VMERGE;
                2'd1:    ins.op = VMUL;
                default: ins.op = vop_e'(3'(r[15:8] % 8'd5));
            endcase
        end
        K_MOVE:  ins.op = VMV_X_S;
        default: ins.op = VADD;
    endcase
    return ins;
endfunction

task automatic next_cycle();
    @(posedge clk_i);
    cyc = cyc + 1;
endtask

task automatic issue_one(input int kind);
    simd_issue_t ins;
    logic [2:0]  slot;
    ins = random_instr(kind);
    next_cycle();
    slot = 3'(cyc + completion_delay(ins));
    if (ins.valid && exp_busy[slot]) begin
        ins.valid = 1'b0;  // Would finish in the same cycle as an op in flight
        bubbles   = bubbles + 1;
    end
    if (ins.valid) begin
        exp_busy[slot]   = 1'b1;
        exp_scalar[slot] = (ins.op == VMV_X_S);
        exp_vec[slot]    = '{valid: 1'b1, vd: ins.vd, vresult: model_vec(ins)};
        exp_sc[slot]     = '{valid: 1'b1, rd: ins.rd, result: model_scalar(ins)};
    end
    instruction_i <= ins;
endtask

task automatic run_test(input string name, input int kind, input int count);
    int err0;
    err0 = errors;
    for (int i = 0; i < count; i++) begin
        issue_one(kind);
    end
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
        issue_one(K_IDLE);
    end
    $display("Test %s: %0d cycles, %0d errors", name, count, errors - err0);
endtask

task automatic report_error(input string what);
    $display("ERROR at cycle %0d: %s", cyc, what);
    errors = errors + 1;
endtask

task automatic check_vec(input wb_vec_t got, input wb_vec_t exp);
    checks = checks + 1;
    if (got !== exp) begin
        $display("MISMATCH wb_vec_o at cycle %0d: got %h, expected %h", cyc, got, exp);
        errors = errors + 1;
    end
endtask

task automatic check_scalar(input wb_scalar_t got, input wb_scalar_t exp);
    checks = checks + 1;
    if (got !== exp) begin
        $display("MISMATCH wb_scalar_o at cycle %0d: got %h, expected %h", cyc, got, exp);
        errors = errors + 1;
    end
endtask

// Outputs are sampled mid-cycle, away from the driving edge
always @(negedge clk_i) begin
    logic [2:0] slot;
    slot = 3'(cyc);
    if (exp_busy[slot] && exp_scalar[slot]) begin
        if (!wb_scalar_o.valid) begin
            report_error("expected scalar write-back did not appear");
        end else begin
            check_scalar(wb_scalar_o, exp_sc[slot]);
        end
        if (wb_vec_o.valid) begin
            report_error("vector write-back valid during a scalar move");
        end
    end else if (exp_busy[slot]) begin
        if (!wb_vec_o.valid) begin
            report_error("expected vector write-back did not appear");
        end else begin
            check_vec(wb_vec_o, exp_vec[slot]);
        end
        if (wb_scalar_o.valid) begin
            report_error("scalar write-back valid during a vector op");
        end
    end else begin
        if (wb_vec_o.valid) begin
            report_error("vector write-back valid with nothing in flight");
        end
        if (wb_scalar_o.valid) begin
            report_error("scalar write-back valid with nothing in flight");
        end
    end
    exp_busy[slot] = 1'b0;
end

initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
end

initial begin
    clk_i         = 1'b0;
    rstn_i        = 1'b0;
    instruction_i = '0;
    seed          = 32'ha6001e14;
    cyc           = 0;
    errors        = 0;
    checks        = 0;
    bubbles       = 0;
    exp_busy      = '0;
    exp_scalar    = '0;
    repeat (RESET_CYCLES) next_cycle();
    rstn_i <= 1'b1;
    run_test("idle after reset", K_IDLE, N_IDLE);
    run_test("unmasked ALU", K_ALU, N_ALU);
    run_test("VMUL back to back", K_MUL, N_MUL);
    run_test("masked and VMERGE", K_MASK, N_MASK);
    run_test("VMV_X_S", K_MOVE, N_MOVE);
    $display("Totals: %0d checks, %0d errors, %0d bubbles", checks, errors, bubbles);
    if (errors == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
+incdir+verif
src/simd_pkg.sv
src/simd_operand_prep.sv
src/simd_lane_fu.sv
src/simd_latency_pipe.sv
src/simd_writeback.sv
src/simd_unit.sv
verif/tb_simd_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failures
rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_simd_unit -o tb_simd_unit \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_simd_unit > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
